// ==== src.f ====
+incdir+include
source/periph_bus_pkg.sv
source/uart_pkg.sv
source/uart_core_if.sv
source/uart_fifo.sv
source/uart_serial.sv
source/uart_regs.sv
source/periph_uart_top.sv
bench/periph_uart_assertions.sv
bench/tb_periph_uart.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run the UART peripheral testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_periph_uart -f src.f -o tb_periph_uart

status=0
./obj_dir/tb_periph_uart > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log || grep -q "%Error" sim.log || [ "$status" -ne 0 ] \
   || ! grep -q "Result: PASSED" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// ==== bench/tb_periph_uart.sv ====
// ****************************************
// UART peripheral testbench
// loopback, bit period, counts, framing error, window decode, full tx FIFO
// ****************************************

`timescale 1ns/1ps

`include "periph_defines.svh"

module tb_periph_uart;

   localparam int WAIT_LIMIT = 4000;                  // cycles allowed per wait
   localparam int CNT_MASK   = (1 << `UART_CNT_W) - 1;

   logic        msoc_clk;
   logic        rstn;
   logic        hid_en_i;
   logic [7:0]  hid_we_i;
   logic [17:0] hid_addr_i;
   logic [63:0] hid_wrdata_i;
   logic [63:0] hid_rddata_o;
   logic        uart_rx_i;
   logic        uart_tx_o;
   logic        uart_irq_o;

   logic        loop_sel;          // 1 routes tx back to rx
   logic        drv_rx;            // hand-built frames
   logic        timeout_hit;
   string       timeout_msg;
   int unsigned lcg_state;
   logic [8:0]  exp_q[$];          // {err, byte} in arrival order
   int          n_tx_push;
   int          n_tx_pop;
   int          n_rx_push;
   int          n_rx_pop;
   int          n_checks;
   int          n_errors;
   string       what_q[$];
   logic [63:0] got_q[$];
   logic [63:0] want_q[$];
   time         at_q[$];

   assign uart_rx_i = loop_sel ? uart_tx_o : drv_rx;

   periph_uart_top u_periph_uart_top (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en_i),
      .hid_we_i     (hid_we_i),
      .hid_addr_i   (hid_addr_i),
      .hid_wrdata_i (hid_wrdata_i),
      .hid_rddata_o (hid_rddata_o),
      .uart_rx_i    (uart_rx_i),
      .uart_tx_o    (uart_tx_o),
      .uart_irq_o   (uart_irq_o)
   );

   always #20 msoc_clk = ~msoc_clk;

   function automatic logic [17:0] bus_addr(input logic [2:0] region, input logic win,
                                            input logic [1:0] sel);
      return {region, win, sel, 12'h000};
   endfunction

   function automatic logic [17:0] uart_addr(input logic [1:0] sel);
      return bus_addr(3'(`PERIPH_REGION_UART), 1'b1, sel);
   endfunction

   function automatic logic [7:0] next_rand_byte();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];   // upper bits are the better ones
   endfunction

   // status word for the bytes not yet popped
   function automatic logic [63:0] expected_status();
      int          level;
      logic [63:0] w;
      level = n_rx_push - n_rx_pop;
      w = '0;
      if (level == 0)
         w[9] = 1'b1;
      else
         w[8:0] = exp_q[0];
      w[10] = ((n_tx_push - n_tx_pop) >= `UART_FIFO_DEPTH);   // bytes left in the tx FIFO
      w[11] = (level >= `UART_FIFO_DEPTH);
      return w;
   endfunction

   function automatic logic [63:0] expected_counts();
      logic [63:0] w;
      w = '0;
      w[11:0]  = 12'(n_rx_pop & CNT_MASK);
      w[27:16] = 12'(n_rx_push & CNT_MASK);
      w[43:32] = 12'(n_tx_pop & CNT_MASK);
      w[59:48] = 12'(n_tx_push & CNT_MASK);
      return w;
   endfunction

   task automatic post_check(input string what, input logic [63:0] got, input logic [63:0] want);
      what_q.push_back(what);
      got_q.push_back(got);
      want_q.push_back(want);
      at_q.push_back($time);
   endtask

   task automatic park_on_timeout(input string msg);
      timeout_msg = msg;
      timeout_hit = 1'b1;
      forever @(posedge msoc_clk);     // the watcher ends the run
   endtask

   task automatic bus_write(input logic [17:0] addr, input logic [63:0] data);
      @(posedge msoc_clk);
      hid_en_i     <= 1'b1;
      hid_we_i     <= 8'hff;
      hid_addr_i   <= addr;
      hid_wrdata_i <= data;
      @(posedge msoc_clk);              // write lands here
      hid_en_i     <= 1'b0;
      hid_we_i     <= '0;
   endtask

   task automatic bus_read(input logic [17:0] addr, output logic [63:0] data);
      @(posedge msoc_clk);
      hid_en_i   <= 1'b1;
      hid_we_i   <= '0;
      hid_addr_i <= addr;
      @(negedge msoc_clk);              // read data is combinational
      data = hid_rddata_o;
   endtask

   task automatic push_tx(input logic [7:0] data);
      bus_write(uart_addr(2'd0), 64'(data));
      exp_q.push_back({1'b0, data});
      n_tx_push++;
   endtask

   task automatic pop_rx();
      bus_write(uart_addr(2'd1), '0);
      void'(exp_q.pop_front());
      n_rx_pop++;
   endtask

   task automatic check_status(input string what);
      logic [63:0] rd;
      bus_read(uart_addr(2'd0), rd);
      post_check(what, rd, expected_status());
   endtask

   task automatic check_counts(input string what);
      logic [63:0] rd;
      bus_read(uart_addr(2'd2), rd);
      post_check(what, rd, expected_counts());
   endtask

   task automatic wait_irq(input logic level, input string what);
      int n;
      n = 0;
      @(negedge msoc_clk);
      while ((uart_irq_o !== level) && (n < WAIT_LIMIT))
      begin
         @(negedge msoc_clk);
         n++;
      end
      if (uart_irq_o !== level)
         park_on_timeout(what);
   endtask

   task automatic wait_rx_data(input string what);
      logic [63:0] rd;
      int          n;
      n = 0;
      bus_read(uart_addr(2'd0), rd);
      while (rd[9] && (n < WAIT_LIMIT))    // poll rx_empty
      begin
         bus_read(uart_addr(2'd0), rd);
         n++;
      end
      if (rd[9])
         park_on_timeout(what);
   endtask

   task automatic drive_frame(input logic [7:0] data, input logic stop_bit, input int period);
      logic [9:0] bits;
      bits = {stop_bit, data, 1'b0};
      @(posedge msoc_clk);
      loop_sel <= 1'b0;
      for (int i = 0; i < 10; i++)
      begin
         for (int k = 0; k < period; k++)
         begin
            @(posedge msoc_clk);
            drv_rx <= bits[i];
         end
      end
      @(posedge msoc_clk);
      drv_rx   <= 1'b1;
      loop_sel <= 1'b1;                 // both sources idle high
   endtask

   task automatic flush_checks();
      int n;
      n = 0;
      while ((got_q.size() > 0) && (n < WAIT_LIMIT))
      begin
         @(negedge msoc_clk);
         n++;
      end
      if (got_q.size() > 0)
         park_on_timeout("drain of the compare queue");
   endtask

   always @(negedge msoc_clk)
   begin : compare_results
      while (got_q.size() > 0)
      begin
         n_checks++;
         if (got_q[0] !== want_q[0])
         begin
            n_errors++;
            $display("** Error at %0t: %s read %h, expected %h",
                     at_q[0], what_q[0], got_q[0], want_q[0]);
         end
         void'(what_q.pop_front());
         void'(got_q.pop_front());
         void'(want_q.pop_front());
         void'(at_q.pop_front());
      end
   end

   always @(posedge timeout_hit)
   begin
      $display("timeout: %s did not happen within %0d cycles", timeout_msg, WAIT_LIMIT);
      $display("Result: FAILED");
      $finish;
   end

   initial
   begin
      logic [63:0] rd;
      logic [7:0]  b;
      msoc_clk     = 1'b0;
      rstn         = 1'b0;
      hid_en_i     = 1'b0;
      hid_we_i     = '0;
      hid_addr_i   = '0;
      hid_wrdata_i = '0;
      drv_rx       = 1'b1;
      loop_sel     = 1'b1;
      timeout_hit  = 1'b0;
      lcg_state    = 38;
      n_tx_push    = 0;
      n_tx_pop     = 0;
      n_rx_push    = 0;
      n_rx_pop     = 0;
      n_checks     = 0;
      n_errors     = 0;
      repeat (2) @(posedge msoc_clk);
      rstn <= 1'b1;

      @(negedge msoc_clk);
      post_check("irq after reset", 64'(uart_irq_o), 64'd0);
      post_check("tx line after reset", 64'(uart_tx_o), 64'd1);
      check_status("status after reset");
      check_counts("counts after reset");

      // one byte at the reset bit period
      push_tx(next_rand_byte());
      wait_irq(1'b1, "irq for the loopback byte");
      n_tx_pop++;
      n_rx_push++;
      check_status("loopback byte");
      pop_rx();
      wait_irq(1'b0, "irq clear after pop");
      check_status("status after pop");

      bus_write(uart_addr(2'd2), 64'd20);
      for (int i = 0; i < 8; i++)
         push_tx(next_rand_byte());
      for (int i = 0; i < 8; i++)
      begin
         wait_rx_data("short period byte");
         n_tx_pop++;
         n_rx_push++;
         check_status("short period byte");
         pop_rx();
      end
      check_status("status after short period run");
      check_counts("counts after loopback");

      // stop bit held low
      b = next_rand_byte();
      exp_q.push_back({1'b1, b});
      drive_frame(b, 1'b0, 20);
      wait_rx_data("framing error byte");
      n_rx_push++;
      check_status("framing error byte");
      pop_rx();
      check_status("status after framing error");
      check_counts("counts after framing error");

      for (int r = 0; r < 8; r++)
      begin
         if (r != `PERIPH_REGION_UART)
         begin
            bus_read(bus_addr(3'(r), 1'b1, 2'd0), rd);
            post_check("read of another region", rd, '0);
         end
      end
      bus_read(bus_addr(3'(`PERIPH_REGION_UART), 1'b0, 2'd0), rd);
      post_check("read of region 6 low half", rd, '0);
      bus_read(bus_addr(3'(`PERIPH_REGION_UART), 1'b0, 2'd2), rd);
      post_check("count read of region 6 low half", rd, '0);
      bus_write(bus_addr(3'(`PERIPH_REGION_UART), 1'b0, 2'd0), 64'h5a);
      bus_write(bus_addr(3'd3, 1'b1, 2'd0), 64'ha5);
      bus_write(bus_addr(3'd5, 1'b1, 2'd1), '0);
      check_status("status after writes outside the window");
      check_counts("counts after writes outside the window");

      // burst behind one frame on the wire fills the tx FIFO
      push_tx(next_rand_byte());
      n_tx_pop++;                       // idle sequencer takes it at once
      for (int i = 0; i < `UART_FIFO_DEPTH; i++)
         push_tx(next_rand_byte());
      check_status("status with the tx FIFO full");
      bus_write(uart_addr(2'd0), 64'hc3);  // no room, dropped
      check_counts("counts after a push into a full tx FIFO");
      for (int i = 0; i <= `UART_FIFO_DEPTH; i++)
      begin
         wait_rx_data("byte from the full tx FIFO");
         if (i > 0)
            n_tx_pop++;                 // popped when the frame before it ended
         n_rx_push++;
         check_status("byte from the full tx FIFO");
         pop_rx();
      end
      check_counts("counts after the tx FIFO drains");

      flush_checks();
      $display("checks: %0d  errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== bench/periph_uart_assertions.sv ====
// ****************************************
// UART register block checks
// irq timing, start pulse, pushes into a full FIFO
// ****************************************

`timescale 1ns/1ps

module periph_uart_assertions
(
   input logic                  msoc_clk,
   input logic                  rstn,
   input logic                  irq_i,
   input uart_pkg::uart_count_t rx_push_cnt_i,
   input uart_pkg::uart_count_t rx_pop_cnt_i,
   input logic                  tx_start_i,
   input logic                  tx_busy_i,
   input logic                  tx_push_i,
   input logic                  tx_full_i,
   input uart_pkg::uart_count_t tx_push_cnt_i
);

   // data is waiting while the push count is ahead of the pop count
   irq_follows_rx: assert property (@(posedge msoc_clk) disable iff (!rstn)
      irq_i == $past(rx_push_cnt_i != rx_pop_cnt_i))
      else $error("irq does not follow the rx FIFO state one cycle later");

   start_then_busy: assert property (@(posedge msoc_clk) disable iff (!rstn)
      tx_start_i |=> (tx_busy_i && !tx_start_i))
      else $error("tx start is not a single pulse followed by busy");

   tx_full_drop: assert property (@(posedge msoc_clk) disable iff (!rstn)
      (tx_push_i && tx_full_i) |=> (tx_push_cnt_i == $past(tx_push_cnt_i)))
      else $error("tx FIFO accepted a push while full");

endmodule

bind uart_regs periph_uart_assertions u_uart_assertions (
   .msoc_clk      (msoc_clk),
   .rstn          (rstn),
   .irq_i         (irq_o),
   .rx_push_cnt_i (rx_push_cnt),
   .rx_pop_cnt_i  (rx_pop_cnt),
   .tx_start_i    (core.tx_start),
   .tx_busy_i     (core.tx_busy),
   .tx_push_i     (tx_push),
   .tx_full_i     (tx_full),
   .tx_push_cnt_i (tx_push_cnt)
);

// ==== source/periph_uart_top.sv ====
// ****************************************
// peripheral UART top
// host bus region decode around the UART
// ****************************************

`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_uart_top
(
   input  logic                      msoc_clk,
   input  logic                      rstn,
   input  logic                      hid_en_i,
   input  periph_bus_pkg::hid_be_t   hid_we_i,
   input  logic [`HID_ADDR_W-1:0]    hid_addr_i,
   input  periph_bus_pkg::hid_data_t hid_wrdata_i,
   output periph_bus_pkg::hid_data_t hid_rddata_o,
   input  logic                      uart_rx_i,
   output logic                      uart_tx_o,
   output logic                      uart_irq_o
);

   periph_bus_pkg::hid_region_t region;
   periph_bus_pkg::uart_reg_t   reg_sel;
   periph_bus_pkg::hid_data_t   uart_rddata;
   logic                        uart_sel;
   logic                        bus_wr;

   assign region   = hid_addr_i[`HID_ADDR_W-1:`HID_REGION_LSB];
   assign uart_sel = (region == periph_bus_pkg::hid_region_t'(`PERIPH_REGION_UART)) &&
                     hid_addr_i[`HID_UART_WIN_BIT];        // bit 14 clear is unused now
   assign reg_sel  = periph_bus_pkg::uart_reg_t'(hid_addr_i[`HID_REG_LSB+1:`HID_REG_LSB]);
   assign bus_wr   = hid_en_i & (|hid_we_i);

   assign hid_rddata_o = uart_sel ? uart_rddata : '0;     // nothing else answers

   uart_core_if u_core_if ();

   uart_regs u_uart_regs (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .sel_i    (uart_sel),
      .wr_i     (bus_wr),
      .reg_i    (reg_sel),
      .wrdata_i (hid_wrdata_i),
      .rddata_o (uart_rddata),
      .irq_o    (uart_irq_o),
      .core     (u_core_if.regs)
   );

   uart_serial u_uart_serial (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .rx_i     (uart_rx_i),
      .tx_o     (uart_tx_o),
      .core     (u_core_if.serial)
   );

endmodule

// ==== source/uart_regs.sv ====
// ****************************************
// UART register block
// bus decode, bit period, tx sequencer, FIFOs, read mux
// ****************************************

`timescale 1ns/1ps

`include "periph_defines.svh"

module uart_regs
(
   input  logic                    msoc_clk,
   input  logic                    rstn,
   input  logic                    sel_i,
   input  logic                    wr_i,
   input  periph_bus_pkg::uart_reg_t reg_i,
   input  periph_bus_pkg::hid_data_t wrdata_i,
   output periph_bus_pkg::hid_data_t rddata_o,
   output logic                    irq_o,
   uart_core_if.regs               core
);

   logic                    tx_push;
   logic                    rx_pop;
   logic                    baud_wr;
   uart_pkg::uart_baud_t    baud_q;
   uart_pkg::utx_state_t    state_q;
   uart_pkg::utx_state_t    state_d;
   uart_pkg::uart_tx_data_t tx_head;
   uart_pkg::uart_tx_data_t tx_byte_q;
   logic                    tx_full;
   logic                    tx_empty;
   uart_pkg::uart_count_t   tx_push_cnt;
   uart_pkg::uart_count_t   tx_pop_cnt;
   uart_pkg::uart_rx_data_t rx_wr_data;
   uart_pkg::uart_rx_data_t rx_head;
   logic                    rx_full;
   logic                    rx_empty;
   uart_pkg::uart_count_t   rx_push_cnt;
   uart_pkg::uart_count_t   rx_pop_cnt;
   uart_pkg::uart_status_t  status;
   logic                    irq_q;

   always_comb
   begin
      tx_push = 1'b0;
      rx_pop  = 1'b0;
      baud_wr = 1'b0;
      if (sel_i && wr_i)
      begin
         case (reg_i)
            periph_bus_pkg::UREG_TX_PUSH: tx_push = 1'b1;
            periph_bus_pkg::UREG_RX_POP:  rx_pop  = 1'b1;
            periph_bus_pkg::UREG_BAUD:    baud_wr = 1'b1;
            periph_bus_pkg::UREG_RSVD:    ;                 // write ignored
            default:                      ;
         endcase
      end
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_q  <= uart_pkg::uart_baud_t'(`UART_BAUD_DEFAULT);
         state_q <= uart_pkg::IDLE;
         irq_q   <= 1'b0;
      end
      else
      begin
         if (baud_wr)
            baud_q <= wrdata_i[15:0];
         state_q <= state_d;
         irq_q   <= ~rx_empty;     // irq while data is waiting
      end
   end

   // tx sequencer
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         uart_pkg::IDLE:  state_d = uart_pkg::EMPTY;
         uart_pkg::EMPTY:
            if (!tx_empty)
               state_d = uart_pkg::POP;
         uart_pkg::POP:   state_d = uart_pkg::START;
         uart_pkg::START: state_d = uart_pkg::INUSE;
         uart_pkg::INUSE:
            if (!core.tx_busy)
               state_d = uart_pkg::IDLE;
         default:         state_d = uart_pkg::IDLE;
      endcase
   end

   // head moves on at the pop, keep the byte for the start pulse
   always_ff @(posedge msoc_clk)
   begin
      if (state_q == uart_pkg::POP)
         tx_byte_q <= tx_head;
   end

   assign core.tx_start   = (state_q == uart_pkg::START);
   assign core.tx_byte    = tx_byte_q;
   assign core.bit_period = baud_q;

   uart_fifo #(.payload_t(uart_pkg::uart_tx_data_t)) u_tx_fifo (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .push_i      (tx_push),
      .push_data_i (wrdata_i[7:0]),
      .pop_i       (state_q == uart_pkg::POP),
      .head_o      (tx_head),
      .full_o      (tx_full),
      .empty_o     (tx_empty),
      .push_cnt_o  (tx_push_cnt),
      .pop_cnt_o   (tx_pop_cnt)
   );

   assign rx_wr_data.err  = core.rx_err;
   assign rx_wr_data.data = core.rx_byte;

   uart_fifo #(.payload_t(uart_pkg::uart_rx_data_t)) u_rx_fifo (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .push_i      (core.rx_valid),    // no back-pressure
      .push_data_i (rx_wr_data),
      .pop_i       (rx_pop),
      .head_o      (rx_head),
      .full_o      (rx_full),
      .empty_o     (rx_empty),
      .push_cnt_o  (rx_push_cnt),
      .pop_cnt_o   (rx_pop_cnt)
   );

   assign status.rx_full  = rx_full;
   assign status.tx_full  = tx_full;
   assign status.rx_empty = rx_empty;
   assign status.rx_head  = rx_head;

   // address bit 13 picks the count word
   assign rddata_o = reg_i[1] ?
                     {16'(tx_push_cnt), 16'(tx_pop_cnt), 16'(rx_push_cnt), 16'(rx_pop_cnt)} :
                     periph_bus_pkg::hid_data_t'(status);

   assign irq_o = irq_q;

endmodule

// ==== source/uart_serial.sv ====
// ****************************************
// UART serial engine
// rx majority filter, 8N1 transmitter and receiver
// ****************************************

`timescale 1ns/1ps

module uart_serial
(
   input  logic msoc_clk,
   input  logic rstn,
   input  logic rx_i,
   output logic tx_o,
   uart_core_if.serial core
);

   logic [2:0]              rx_samp;
   logic                    rx_maj;
   logic                    rx_maj_q;

   uart_pkg::uart_baud_t    tx_cnt;
   logic [3:0]              tx_left;
   logic [9:0]              tx_sh;
   logic                    tx_busy_q;

   uart_pkg::uart_baud_t    rx_cnt;
   logic [3:0]              rx_idx;
   logic                    rx_busy;
   logic                    rx_tick;
   logic                    rx_valid_q;
   uart_pkg::uart_tx_data_t rx_sh;
   logic                    rx_err_q;

   // three samples, two of three wins
   assign rx_maj = (rx_samp[0] & rx_samp[1]) |
                   (rx_samp[1] & rx_samp[2]) |
                   (rx_samp[0] & rx_samp[2]);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rx_samp  <= 3'b111;    // idle line is high
         rx_maj_q <= 1'b1;
      end
      else
      begin
         rx_samp  <= {rx_samp[1:0], rx_i};
         rx_maj_q <= rx_maj;
      end
   end

   // transmitter shifts {stop, data, start} out lsb first
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_sh     <= '1;
         tx_cnt    <= '0;
         tx_left   <= '0;
         tx_busy_q <= 1'b0;
      end
      else if (!tx_busy_q)
      begin
         if (core.tx_start)
         begin
            tx_sh     <= {1'b1, core.tx_byte, 1'b0};
            tx_cnt    <= core.bit_period - 1'b1;
            tx_left   <= 4'd9;            // shifts after the start bit
            tx_busy_q <= 1'b1;
         end
      end
      else if (tx_cnt != '0)
         tx_cnt <= tx_cnt - 1'b1;
      else if (tx_left != '0)
      begin
         tx_sh   <= {1'b1, tx_sh[9:1]};  // fill with idle ones
         tx_left <= tx_left - 1'b1;
         tx_cnt  <= core.bit_period - 1'b1;
      end
      else
         tx_busy_q <= 1'b0;              // stop bit done
   end

   assign tx_o         = tx_sh[0];
   assign core.tx_busy = tx_busy_q;

   // receiver waits half a bit after the falling edge, then one bit per sample
   assign rx_tick = rx_busy && (rx_cnt == '0);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rx_busy    <= 1'b0;
         rx_cnt     <= '0;
         rx_idx     <= '0;
         rx_valid_q <= 1'b0;
      end
      else
      begin
         rx_valid_q <= 1'b0;
         if (!rx_busy)
         begin
            if (rx_maj_q && !rx_maj)      // falling edge
            begin
               rx_busy <= 1'b1;
               rx_cnt  <= core.bit_period >> 1;
               rx_idx  <= '0;
            end
         end
         else if (!rx_tick)
            rx_cnt <= rx_cnt - 1'b1;
         else
         begin
            rx_cnt <= core.bit_period - 1'b1;
            rx_idx <= rx_idx + 1'b1;
            if ((rx_idx == 4'd0) && rx_maj)
               rx_busy <= 1'b0;            // glitch, not a start bit
            else if (rx_idx == 4'd9)
            begin
               rx_busy    <= 1'b0;
               rx_valid_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (rx_tick && (rx_idx >= 4'd1) && (rx_idx <= 4'd8))
         rx_sh <= {rx_maj, rx_sh[7:1]};    // lsb arrives first
      if (rx_tick && (rx_idx == 4'd9))
         rx_err_q <= ~rx_maj;              // bad stop bit
   end

   assign core.rx_valid = rx_valid_q;
   assign core.rx_byte  = rx_sh;
   assign core.rx_err   = rx_err_q;

endmodule

// ==== source/uart_fifo.sv ====
// ****************************************
// UART FIFO
// show-ahead circular buffer with wrapping push/pop counts
// ****************************************

`timescale 1ns/1ps

`include "periph_defines.svh"

module uart_fifo #(
   parameter type payload_t = logic [7:0]
)
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  logic                  push_i,
   input  payload_t              push_data_i,
   input  logic                  pop_i,
   output payload_t              head_o,
   output logic                  full_o,
   output logic                  empty_o,
   output uart_pkg::uart_count_t push_cnt_o,
   output uart_pkg::uart_count_t pop_cnt_o
);

   localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

   payload_t              mem [`UART_FIFO_DEPTH];
   uart_pkg::uart_count_t push_cnt;
   uart_pkg::uart_count_t pop_cnt;
   uart_pkg::uart_count_t fill;
   logic                  push_ok;
   logic                  pop_ok;

   // depth divides the counter range, so the low count bits address the buffer
   assign fill    = push_cnt - pop_cnt;
   assign full_o  = (fill == uart_pkg::uart_count_t'(`UART_FIFO_DEPTH));
   assign empty_o = (fill == '0);
   assign push_ok = push_i & ~full_o;    // full drops the push
   assign pop_ok  = pop_i & ~empty_o;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         push_cnt <= '0;
         pop_cnt  <= '0;
      end
      else
      begin
         if (push_ok)
            push_cnt <= push_cnt + 1'b1;
         if (pop_ok)
            pop_cnt <= pop_cnt + 1'b1;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (push_ok)
         mem[push_cnt[PTR_W-1:0]] <= push_data_i;
   end

   assign head_o     = empty_o ? payload_t'('0) : mem[pop_cnt[PTR_W-1:0]];  // zero when empty
   assign push_cnt_o = push_cnt;
   assign pop_cnt_o  = pop_cnt;

endmodule

// ==== source/uart_core_if.sv ====
// ****************************************
// UART core link
// register block to serial engine signals
// ****************************************

`timescale 1ns/1ps

interface uart_core_if;

   logic                      tx_start;     // one cycle pulse
   uart_pkg::uart_tx_data_t   tx_byte;
   logic                      rx_valid;     // one cycle pulse
   uart_pkg::uart_tx_data_t   rx_byte;
   logic                      rx_err;       // stop bit sampled low
   logic                      tx_busy;
   uart_pkg::uart_baud_t      bit_period;

   modport regs
   (
      output tx_start, tx_byte, bit_period,
      input  rx_valid, rx_byte, rx_err, tx_busy
   );

   modport serial
   (
      input  tx_start, tx_byte, bit_period,
      output rx_valid, rx_byte, rx_err, tx_busy
   );

endinterface

// ==== source/uart_pkg.sv ====
// ****************************************
// UART types
// payloads, transmit sequencer states, status word
// ****************************************

`include "periph_defines.svh"

package uart_pkg;

   typedef logic [7:0] uart_tx_data_t;

   // byte with its stop bit error, error in the top bit
   typedef struct packed
   {
      logic          err;
      uart_tx_data_t data;
   } uart_rx_data_t;

   typedef enum logic [2:0]
   {
      IDLE,
      EMPTY,    // waiting for a byte
      POP,
      START,    // start pulse to the serial engine
      INUSE     // frame on the wire
   } utx_state_t;

   typedef logic [`UART_CNT_W-1:0] uart_count_t;
   typedef logic [15:0]            uart_baud_t;   // clocks per bit

   // low 12 bits of the status read word
   typedef struct packed
   {
      logic          rx_full;
      logic          tx_full;
      logic          rx_empty;
      uart_rx_data_t rx_head;
   } uart_status_t;

endpackage

// ==== source/periph_bus_pkg.sv ====
// ****************************************
// host bus types
// data word, byte enables, region and UART register select
// ****************************************

package periph_bus_pkg;

   typedef logic [63:0] hid_data_t;    // bus word
   typedef logic [7:0]  hid_be_t;      // byte write enables
   typedef logic [2:0]  hid_region_t;  // address bits 17..15

   // register select from address bits 13..12
   typedef enum logic [1:0]
   {
      UREG_TX_PUSH = 2'd0,    // push a transmit byte
      UREG_RX_POP  = 2'd1,    // pop the receive FIFO
      UREG_BAUD    = 2'd2,    // bit period
      UREG_RSVD    = 2'd3
   } uart_reg_t;

endpackage

// ==== include/periph_defines.svh ====
// ****************************************
// peripheral defines
// reset values, FIFO sizing and bus address fields
// ****************************************

`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// UART timing and buffering
`define UART_BAUD_DEFAULT 54     // clocks per bit after reset
`define UART_FIFO_DEPTH 16       // entries per FIFO
`define UART_CNT_W 12            // push/pop counter width

// host bus address layout
`define HID_ADDR_W 18            // full address width
`define HID_REGION_LSB 15        // region field is [17:15]
`define HID_UART_WIN_BIT 14      // set selects the UART half
`define HID_REG_LSB 12           // register select is [13:12]

// region map
`define PERIPH_REGION_UART 6

`endif
